//--- design/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    ////////////////////////////////////////////////////////////
    // Frame format

    localparam int data_width  = 8;                   // Bits per character
    localparam int oversample  = 16;                  // Ticks per bit
    localparam int mid_sample  = oversample / 2 - 1;  // Sample point inside a bit
    localparam int last_sample = oversample - 1;

    ////////////////////////////////////////////////////////////
    // Channels, buffer and tick rate

    localparam int num_chan   = 2;
    localparam int chan_w     = 1;
    localparam int fifo_depth = 8;  // Power of two
    localparam int tick_div   = 4;  // clk cycles per oversampling tick

    ////////////////////////////////////////////////////////////
    // Payload types

    // One received character
    typedef struct packed {
        logic [data_width-1:0] data;       // LSB received first
        logic                  frame_err;  // Stop bit was low
    } rx_byte_t;

    // One receive buffer entry
    typedef struct packed {
        logic [chan_w-1:0] chan;
        rx_byte_t          rx_byte;
    } rx_entry_t;

endpackage

`default_nettype wire

//--- design/baud_tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module baud_tick_gen (
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    typedef logic [$clog2(uart_rx_pkg::tick_div)-1:0] div_cnt_t;

    div_cnt_t div_cnt;

    // One-cycle pulse on the last count of each period
    assign tick = (div_cnt == div_cnt_t'(uart_rx_pkg::tick_div - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;                // Wrap
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  tick,
    input  logic                  rx,
    output logic                  done,
    output uart_rx_pkg::rx_byte_t byte_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    typedef logic [$clog2(uart_rx_pkg::oversample)-1:0] tick_cnt_t;
    typedef logic [$clog2(uart_rx_pkg::data_width)-1:0] bit_cnt_t;

    state_t                             state;
    tick_cnt_t                          tick_cnt;   // Ticks seen in the current bit
    bit_cnt_t                           bit_cnt;    // Data bit index
    logic [uart_rx_pkg::data_width-1:0] shift;
    logic [1:0]                         rx_sync;
    logic                               rx_s;
    logic                               start_seen;
    logic                               mid_tick;
    logic                               last_tick;

    ////////////////////////////////////////////////////////////
    // Line synchronizer

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11;                  // Idle line level
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    assign rx_s = rx_sync[1];

    // Start is detected on a tick, which keeps every later sample inside its bit
    assign start_seen = (state == st_idle) && tick && !rx_s;
    assign mid_tick   = tick && (tick_cnt == tick_cnt_t'(uart_rx_pkg::mid_sample));
    assign last_tick  = tick && (tick_cnt == tick_cnt_t'(uart_rx_pkg::last_sample));

    ////////////////////////////////////////////////////////////
    // Frame FSM

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            shift    <= '0;
            done     <= 1'b0;
            byte_out <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_seen) begin
                        tick_cnt <= tick_cnt_t'(1);   // Detecting tick counts as sample 0
                        bit_cnt  <= '0;
                        state    <= st_start;
                    end
                end
                st_start: begin
                    if (mid_tick && rx_s) begin
                        state <= st_idle;             // Glitch, drop it
                    end else if (last_tick) begin
                        tick_cnt <= '0;
                        state    <= st_data;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (mid_tick) begin
                        shift <= {rx_s, shift[uart_rx_pkg::data_width-1:1]};
                    end
                    if (last_tick) begin
                        tick_cnt <= '0;
                        if (bit_cnt == bit_cnt_t'(uart_rx_pkg::data_width - 1)) begin
                            state <= st_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    // Low stop bit ends the frame at once
                    if (tick && (!rx_s || last_tick)) begin
                        done               <= 1'b1;
                        byte_out.data      <= shift;
                        byte_out.frame_err <= !rx_s;
                        state              <= st_idle;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Ticks are tick_div cycles apart, so no start can be seen right after a stop tick
    assert property (@(posedge clk) disable iff (!arst_n) !(done && start_seen))
        else $error("uart_rx: done and start detection in the same cycle");

endmodule

`default_nettype wire

//--- design/rx_write_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rx_write_arbiter (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  logic [uart_rx_pkg::num_chan-1:0]                  done,
    input  uart_rx_pkg::rx_byte_t [uart_rx_pkg::num_chan-1:0] byte_in,
    output logic                                              wr_en,
    output uart_rx_pkg::rx_entry_t                            wr_data
);

    typedef logic [uart_rx_pkg::chan_w-1:0] chan_t;

    logic [uart_rx_pkg::num_chan-1:0]                  pending;
    uart_rx_pkg::rx_byte_t [uart_rx_pkg::num_chan-1:0] held;
    logic [uart_rx_pkg::num_chan-1:0]                  grant_mask;
    chan_t                                             last_chan;   // Last granted channel
    chan_t                                             grant_chan;
    logic                                              grant_valid;

    // Round robin, nearest pending channel after the last grant wins
    always_comb begin
        chan_t idx;
        idx         = last_chan;
        grant_chan  = last_chan;
        grant_valid = 1'b0;
        for (int k = uart_rx_pkg::num_chan; k >= 1; k--) begin
            idx = last_chan + chan_t'(k);
            if (pending[idx]) begin
                grant_chan  = idx;
                grant_valid = 1'b1;
            end
        end
        grant_mask             = '0;
        grant_mask[grant_chan] = grant_valid;
    end

    assign wr_en   = grant_valid;
    assign wr_data = '{chan: grant_chan, rx_byte: held[grant_chan]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending   <= '0;
            last_chan <= '0;
        end else begin
            pending <= done | (pending & ~grant_mask);
            if (grant_valid) begin
                last_chan <= grant_chan;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < uart_rx_pkg::num_chan; i++) begin
            if (done[i]) begin
                held[i] <= byte_in[i];            // Byte copy per channel
            end
        end
    end

    // A frame lasts far longer than the drain time, so no byte is overwritten
    assert property (@(posedge clk) disable iff (!arst_n) (done & pending) == '0)
        else $error("rx_write_arbiter: done while channel still pending");

endmodule

`default_nettype wire

//--- design/rx_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module rx_buffer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_en,
    input  uart_rx_pkg::rx_entry_t wr_data,
    input  logic                   rd_en,
    output uart_rx_pkg::rx_entry_t rd_data,
    output logic                   rd_valid,
    output logic                   overflow
);

    typedef logic [$clog2(uart_rx_pkg::fifo_depth)-1:0] ptr_t;
    typedef logic [$clog2(uart_rx_pkg::fifo_depth):0]   count_t;

    uart_rx_pkg::rx_entry_t mem [uart_rx_pkg::fifo_depth];
    ptr_t                   wr_ptr;
    ptr_t                   rd_ptr;
    count_t                 count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign full     = (count == count_t'(uart_rx_pkg::fifo_depth));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];            // Oldest entry falls through
    assign do_wr    = wr_en && !full;         // Write into full buffer is dropped
    assign do_rd    = rd_en && rd_valid;

    ////////////////////////////////////////////////////////////
    // Pointers, fill count and overflow flag

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;      // Wraps at the power-of-two depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_en && full) begin
                overflow <= 1'b1;             // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Fill count stays within depth and in step with the pointers
    assert property (@(posedge clk) disable iff (!arst_n)
                     count <= count_t'(uart_rx_pkg::fifo_depth)
                     && ptr_t'(count) == ptr_t'(wr_ptr - rd_ptr))
        else $error("rx_buffer: count above depth or out of step with pointers");

endmodule

`default_nettype wire

//--- design/dual_uart_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module dual_uart_rx_top (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [uart_rx_pkg::num_chan-1:0] rx,
    input  logic                             rd_en,
    output uart_rx_pkg::rx_entry_t           rd_data,
    output logic                             rd_valid,
    output logic                             overflow
);

    logic                                              tick;
    logic [uart_rx_pkg::num_chan-1:0]                  done;
    uart_rx_pkg::rx_byte_t [uart_rx_pkg::num_chan-1:0] rx_byte;
    logic                                              wr_en;
    uart_rx_pkg::rx_entry_t                            wr_data;

    // Shared oversampling tick
    baud_tick_gen baud_tick_gen_i (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick)
    );

    ////////////////////////////////////////////////////////////
    // One receiver per serial line

    for (genvar g = 0; g < uart_rx_pkg::num_chan; g++) begin : g_chan
        uart_rx uart_rx_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .tick     (tick),
            .rx       (rx[g]),
            .done     (done[g]),
            .byte_out (rx_byte[g])
        );
    end

    rx_write_arbiter rx_write_arbiter_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .done    (done),
        .byte_in (rx_byte),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    rx_buffer rx_buffer_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .overflow (overflow)
    );

endmodule

`default_nettype wire

//--- test/tb_dual_uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dual_uart_rx;

    localparam int bit_cycles      = uart_rx_pkg::tick_div * uart_rx_pkg::oversample;
    localparam int frame_bits      = uart_rx_pkg::data_width + 2;   // Start, data, stop
    localparam int settle_cycles   = 3 * uart_rx_pkg::tick_div;     // Last stop tick to write
    localparam int max_gap         = 40;
    localparam int num_rows        = 20;
    localparam int watchdog_cycles = num_rows * 12 * bit_cycles + 2000;

    // One row of stimulus
    typedef struct packed {
        logic [1:0]                         mask;      // Bit n drives channel n
        logic [uart_rx_pkg::data_width-1:0] data0;
        logic [uart_rx_pkg::data_width-1:0] data1;
        logic                               stop_ok;
        logic                               glitch;    // Short start pulse only
        logic                               read;      // Host drains after the row
    } row_t;

    localparam row_t rows [num_rows] = '{
        '{2'b01, 8'h55, 8'h00, 1'b1, 1'b0, 1'b1},   // Single frame on channel 0
        '{2'b10, 8'h00, 8'h00, 1'b1, 1'b0, 1'b1},
        '{2'b10, 8'h00, 8'hFF, 1'b1, 1'b0, 1'b1},
        '{2'b10, 8'h00, 8'hA5, 1'b1, 1'b0, 1'b1},
        '{2'b11, 8'h3C, 8'hC3, 1'b1, 1'b0, 1'b1},   // Both lines at once
        '{2'b11, 8'h96, 8'h69, 1'b1, 1'b0, 1'b1},
        '{2'b01, 8'h81, 8'h00, 1'b0, 1'b0, 1'b1},   // Low stop bit
        '{2'b01, 8'h7E, 8'h00, 1'b1, 1'b0, 1'b1},
        '{2'b10, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1},   // Start glitch
        '{2'b10, 8'h00, 8'h5A, 1'b1, 1'b0, 1'b1},
        // Ten frames with no reads, the last two overflow
        '{2'b01, 8'h10, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h11, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h12, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h13, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h14, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h15, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h16, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h17, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h18, 8'h00, 1'b1, 1'b0, 1'b0},
        '{2'b01, 8'h19, 8'h00, 1'b1, 1'b0, 1'b1}
    };

    logic                                   clk;
    logic                                   arst_n;
    logic [uart_rx_pkg::num_chan-1:0]       rx;
    logic                                   rd_en;
    uart_rx_pkg::rx_entry_t                 rd_data;
    logic                                   rd_valid;
    logic                                   overflow;

    uart_rx_pkg::rx_entry_t                 exp_q0 [$];   // Expected entries per channel
    uart_rx_pkg::rx_entry_t                 exp_q1 [$];
    logic                                   host_read;
    logic                                   exp_overflow;
    int                                     fill;         // Entries held while nobody reads
    int                                     errors;

    dual_uart_rx_top dual_uart_rx_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (rx),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .overflow (overflow)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Serial line model

    // Line level during one oversampling tick of a frame
    function automatic logic line_level(input logic [uart_rx_pkg::data_width-1:0] data,
                                        input int bit_idx, input int tick_idx,
                                        input logic stop_ok, input logic glitch);
        logic level;
        if (glitch) begin
            level = !(bit_idx == 0 && tick_idx < 3);
        end else if (bit_idx == 0) begin
            level = 1'b0;
        end else if (bit_idx <= uart_rx_pkg::data_width) begin
            level = data[bit_idx-1];                     // LSB first
        end else begin
            level = stop_ok || (tick_idx >= 4);          // Bad stop is low only at its start
        end
        return level;
    endfunction

    task automatic drive_frames(input row_t row);
        for (int b = 0; b < frame_bits; b++) begin
            for (int t = 0; t < uart_rx_pkg::oversample; t++) begin
                rx[0] = row.mask[0] ? line_level(row.data0, b, t, row.stop_ok, row.glitch) : 1'b1;
                rx[1] = row.mask[1] ? line_level(row.data1, b, t, row.stop_ok, row.glitch) : 1'b1;
                repeat (uart_rx_pkg::tick_div) @(negedge clk);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Prediction and host side

    task automatic expect_row(input row_t row);
        uart_rx_pkg::rx_entry_t entry;
        if (!row.glitch) begin
            for (int c = 0; c < uart_rx_pkg::num_chan; c++) begin
                if (row.mask[c]) begin
                    entry.chan              = (c == 1);
                    entry.rx_byte.data      = (c == 1) ? row.data1 : row.data0;
                    entry.rx_byte.frame_err = !row.stop_ok;
                    if (fill < uart_rx_pkg::fifo_depth) begin
                        if (c == 1) exp_q1.push_back(entry);
                        else exp_q0.push_back(entry);
                        fill++;
                    end else begin
                        exp_overflow = 1'b1;             // Buffer full, entry dropped
                    end
                end
            end
        end
    endtask

    task automatic read_entries();
        uart_rx_pkg::rx_entry_t got;
        uart_rx_pkg::rx_entry_t want;
        int                     avail;
        forever begin
            @(negedge clk);
            rd_en = 1'b0;
            if (host_read && rd_valid) begin
                got   = rd_data;
                avail = got.chan[0] ? exp_q1.size() : exp_q0.size();
                assert (avail > 0) else begin
                    errors++;
                    $display("error: unexpected entry %h from channel %0d at %0t",
                             got.rx_byte.data, got.chan, $time);
                end
                if (avail > 0) begin
                    if (got.chan[0]) want = exp_q1.pop_front();
                    else want = exp_q0.pop_front();
                    assert (got == want) else begin
                        errors++;
                        $display("mismatch at %0t: channel %0d expected %h/%b actual %h/%b",
                                 $time, got.chan, want.rx_byte.data, want.rx_byte.frame_err,
                                 got.rx_byte.data, got.rx_byte.frame_err);
                    end
                end
                rd_en = 1'b1;                            // Pop at the next edge
            end
        end
    endtask

    task automatic drain_buffer();
        @(posedge clk);
        host_read = 1'b1;
        while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge clk);
        host_read = 1'b0;
        fill      = 0;
        @(negedge clk);
        assert (overflow === exp_overflow) else begin
            errors++;
            $display("mismatch at %0t: overflow expected %b actual %b",
                     $time, exp_overflow, overflow);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin : main
        rx           = '1;
        rd_en        = 1'b0;
        arst_n       = 1'b0;
        host_read    = 1'b0;
        exp_overflow = 1'b0;
        fill         = 0;
        errors       = 0;
        void'($urandom(78817));
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        fork
            read_entries();
        join_none
        for (int r = 0; r < num_rows; r++) begin
            expect_row(rows[r]);
            drive_frames(rows[r]);
            repeat (settle_cycles) @(negedge clk);
            repeat ($urandom_range(max_gap)) @(negedge clk);   // Idle gap
            if (rows[r].read) begin
                drain_buffer();
            end
        end
        repeat (bit_cycles) @(negedge clk);
        assert (!rd_valid) else begin
            errors++;
            $display("error: entries left in the buffer at the end of the run");
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("error: run timed out after %0d cycles", watchdog_cycles);
        $display("errors: %0d", errors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/uart_rx_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/rx_write_arbiter.sv
design/rx_buffer.sv
design/dual_uart_rx_top.sv
test/tb_dual_uart_rx.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
    --top-module tb_dual_uart_rx -f verilog.f \
    && out=$(./obj_dir/Vtb_dual_uart_rx) \
    && echo "$out" \
    && echo "$out" | grep -qx "Test passed" \
    || { echo "Simulation did not pass"; exit 1; }
